// File: hw/hemaia_mem_chip_addr_pkg.sv
// HeMAiA memory chip address map
// Address types, local region windows and the decode target encoding

`default_nettype none

package hemaia_mem_chip_addr_pkg;

  typedef logic [7:0] chip_id_t;
  typedef logic [47:0] addr_t;
  typedef logic [39:0] offset_t;

  // Local regions, as offsets below the chip byte
  localparam offset_t MemBaseOffset = 40'h0080000000;
  localparam offset_t ClkCtrlBaseOffset = 40'h0002005000;
  localparam offset_t ClkCtrlEndOffset = 40'h0002006000;

  // 64-bit words, so byte offsets drop three bits
  localparam int unsigned WordByteShift = 3;

  typedef enum logic [1:0] {
    TgtMem     = 2'd0,
    TgtClkCtrl = 2'd1,
    TgtError   = 2'd2
  } target_e;

  // Index width for n entries, never below one bit
  function automatic int unsigned idx_width(input int unsigned n);
    return (n > 1) ? $clog2(n) : 1;
  endfunction

  // Word index must cover both the SRAM words and the divider registers
  function automatic int unsigned word_idx_width(input int unsigned mem_size,
                                                 input int unsigned num_regs);
    int unsigned mem_w;
    int unsigned reg_w;
    mem_w = idx_width(mem_size >> WordByteShift);
    reg_w = idx_width(num_regs);
    return (mem_w > reg_w) ? mem_w : reg_w;
  endfunction

endpackage

`default_nettype wire

// File: hw/hemaia_mem_chip_bus_pkg.sv
// HeMAiA memory chip bus definitions
// Data word, request opcodes and the clock-divider register file

`default_nettype none

package hemaia_mem_chip_bus_pkg;

  typedef logic [63:0] data_t;

  typedef enum logic {
    OpRead  = 1'b0,
    OpWrite = 1'b1
  } op_e;

  ////////////////////////////////////////////////////////////////////////////
  // Clock divider block
  ////////////////////////////////////////////////////////////////////////////

  typedef logic [7:0] div_t;

  // Generated clocks: SRAM clock first, then the four link clocks
  localparam int unsigned NumClocks = 5;

  localparam div_t DefaultDivision[NumClocks] = '{
    8'd4,
    8'd1,
    8'd1,
    8'd1,
    8'd1
  };

endpackage

`default_nettype wire

// File: hw/hemaia_mem_req_if.sv
// Decoded request link
// Carries one classified request from the decode stage to the execute stage

`timescale 1ns/1ps
`default_nettype none

interface hemaia_mem_req_if #(
  parameter int unsigned IdxWidth = 9
);
  import hemaia_mem_chip_addr_pkg::*;
  import hemaia_mem_chip_bus_pkg::*;

  logic                valid;
  op_e                 op;
  target_e             target;
  // Word offset inside the selected target
  logic [IdxWidth-1:0] word_index;
  data_t               wdata;

  modport decode_mp (
    output valid,
    output op,
    output target,
    output word_index,
    output wdata
  );

  modport exec_mp (
    input valid,
    input op,
    input target,
    input word_index,
    input wdata
  );

endinterface

`default_nettype wire

// File: hw/hemaia_addr_decode.sv
// Address decode stage
// Captures the chip ID during reset and classifies each request against
// the local map, then registers it towards the execute stage

`timescale 1ns/1ps
`default_nettype none

module hemaia_addr_decode #(
  parameter int unsigned MemSize = 32'h1000
) (
  input  logic                               clk_i,
  input  logic                               rst_ni,
  input  hemaia_mem_chip_addr_pkg::chip_id_t chip_id_i,
  input  logic                               req_valid_i,
  input  hemaia_mem_chip_bus_pkg::op_e       req_op_i,
  input  hemaia_mem_chip_addr_pkg::addr_t    req_addr_i,
  input  hemaia_mem_chip_bus_pkg::data_t     req_wdata_i,
  hemaia_mem_req_if.decode_mp                req_o
);
  import hemaia_mem_chip_addr_pkg::*;
  import hemaia_mem_chip_bus_pkg::*;

  localparam int unsigned IdxWidth = word_idx_width(MemSize, NumClocks);

  chip_id_t            chip_id_q;
  offset_t             offset;
  offset_t             mem_rel;
  offset_t             clk_rel;
  logic                local_hit;
  logic                mem_hit;
  logic                clk_hit;
  logic                div_in_range;
  target_e             target_d;
  logic [IdxWidth-1:0] idx_d;

  logic                valid_q;
  op_e                 op_q;
  target_e             target_q;
  logic [IdxWidth-1:0] idx_q;
  data_t               wdata_q;

  // Chip ID follows the pins while reset is held
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      chip_id_q <= chip_id_i;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Local address map
  ////////////////////////////////////////////////////////////////////////////

  assign offset       = req_addr_i[39:0];
  assign local_hit    = (req_addr_i[47:40] == chip_id_q);
  assign mem_rel      = offset - MemBaseOffset;
  assign clk_rel      = offset - ClkCtrlBaseOffset;
  assign mem_hit      = (offset >= MemBaseOffset) && (mem_rel < offset_t'(MemSize));
  assign clk_hit      = (offset >= ClkCtrlBaseOffset) && (offset < ClkCtrlEndOffset);
  assign div_in_range = (clk_rel >> WordByteShift) < offset_t'(NumClocks);

  // Remote chips, link control and holes all fall through to the error target
  always_comb begin
    target_d = TgtError;
    idx_d    = '0;
    if (local_hit && mem_hit) begin
      target_d = TgtMem;
      idx_d    = IdxWidth'(mem_rel >> WordByteShift);
    end else if (local_hit && clk_hit && div_in_range) begin
      target_d = TgtClkCtrl;
      idx_d    = IdxWidth'(clk_rel >> WordByteShift);
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= req_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_valid_i) begin
      op_q     <= req_op_i;
      target_q <= target_d;
      idx_q    <= idx_d;
      wdata_q  <= req_wdata_i;
    end
  end

  assign req_o.valid      = valid_q;
  assign req_o.op         = op_q;
  assign req_o.target     = target_q;
  assign req_o.word_index = idx_q;
  assign req_o.wdata      = wdata_q;

  valid_target_known_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    req_o.valid |-> !$isunknown(req_o.target));

endmodule

`default_nettype wire

// File: hw/hemaia_target_exec.sv
// Target execute stage
// Word-interleaved SRAM banks and the clock-divider register file,
// accessed by decoded requests and registered towards the response stage

`timescale 1ns/1ps
`default_nettype none

module hemaia_target_exec #(
  parameter int unsigned MemSize    = 32'h1000,
  parameter int unsigned MemBankNum = 4
) (
  input  logic                                 clk_i,
  input  logic                                 rst_ni,
  hemaia_mem_req_if.exec_mp                    req_i,
  output logic                                 ex_valid_o,
  output hemaia_mem_chip_bus_pkg::op_e         ex_op_o,
  output hemaia_mem_chip_addr_pkg::target_e    ex_target_o,
  output logic [hemaia_mem_chip_addr_pkg::idx_width(MemBankNum)-1:0] ex_bank_o,
  output hemaia_mem_chip_bus_pkg::data_t       ex_bank_rdata_o[MemBankNum],
  output hemaia_mem_chip_bus_pkg::div_t        ex_div_rdata_o,
  output logic                                 ex_err_o
);
  import hemaia_mem_chip_addr_pkg::*;
  import hemaia_mem_chip_bus_pkg::*;

  localparam int unsigned NumWords    = MemSize >> WordByteShift;
  localparam int unsigned RowsPerBank = NumWords / MemBankNum;
  localparam int unsigned BankWidth   = idx_width(MemBankNum);
  localparam int unsigned RowWidth    = idx_width(RowsPerBank);
  localparam int unsigned DivWidth    = idx_width(NumClocks);

  logic                 mem_access;
  logic                 mem_write;
  logic                 div_access;
  logic                 div_write;
  logic [BankWidth-1:0] bank;
  logic [RowWidth-1:0]  row;
  logic [DivWidth-1:0]  div_idx;

  div_t                 div_q[NumClocks];
  div_t                 div_rdata_q;
  logic                 valid_q;
  logic                 err_q;
  op_e                  op_q;
  target_e              target_q;
  logic [BankWidth-1:0] bank_q;

  assign mem_access = req_i.valid && (req_i.target == TgtMem);
  assign mem_write  = mem_access && (req_i.op == OpWrite);
  assign div_access = req_i.valid && (req_i.target == TgtClkCtrl);
  assign div_write  = div_access && (req_i.op == OpWrite);

  // Consecutive words rotate across the banks
  assign bank    = BankWidth'(req_i.word_index % MemBankNum);
  assign row     = RowWidth'(req_i.word_index / MemBankNum);
  assign div_idx = DivWidth'(req_i.word_index);

  ////////////////////////////////////////////////////////////////////////////
  // SRAM banks
  ////////////////////////////////////////////////////////////////////////////

  for (genvar b = 0; b < MemBankNum; b++) begin : gen_bank
    data_t rows_q[RowsPerBank];
    data_t rdata_q;

    always_ff @(posedge clk_i) begin
      if (mem_write && (bank == BankWidth'(b))) begin
        rows_q[row] <= req_i.wdata;
      end
      if (mem_access) begin
        rdata_q <= rows_q[row];
      end
    end

    assign ex_bank_rdata_o[b] = rdata_q;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Clock divider registers
  ////////////////////////////////////////////////////////////////////////////

  // Plain storage, nothing is divided here
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      div_q <= DefaultDivision;
    end else if (div_write) begin
      div_q[div_idx] <= div_t'(req_i.wdata);
    end
  end

  always_ff @(posedge clk_i) begin
    if (div_access) begin
      div_rdata_q <= div_q[div_idx];
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
      err_q   <= 1'b0;
    end else begin
      valid_q <= req_i.valid;
      err_q   <= req_i.valid && (req_i.target == TgtError);
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_i.valid) begin
      op_q     <= req_i.op;
      target_q <= req_i.target;
      bank_q   <= bank;
    end
  end

  assign ex_valid_o     = valid_q;
  assign ex_op_o        = op_q;
  assign ex_target_o    = target_q;
  assign ex_bank_o      = bank_q;
  assign ex_div_rdata_o = div_rdata_q;
  assign ex_err_o       = err_q;

  // Decode must never hand over an SRAM word past the end of the banks
  mem_row_in_range_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    mem_access |-> ((32'(req_i.word_index) / MemBankNum) < RowsPerBank));

endmodule

`default_nettype wire

// File: hw/hemaia_resp_merge.sv
// Response stage
// Picks the read word of the accessed target, zeroes write and error data
// and registers the response

`timescale 1ns/1ps
`default_nettype none

module hemaia_resp_merge #(
  parameter int unsigned MemBankNum = 4
) (
  input  logic                              clk_i,
  input  logic                              rst_ni,
  input  logic                              ex_valid_i,
  input  hemaia_mem_chip_bus_pkg::op_e      ex_op_i,
  input  hemaia_mem_chip_addr_pkg::target_e ex_target_i,
  input  logic [hemaia_mem_chip_addr_pkg::idx_width(MemBankNum)-1:0] ex_bank_i,
  input  hemaia_mem_chip_bus_pkg::data_t    ex_bank_rdata_i[MemBankNum],
  input  hemaia_mem_chip_bus_pkg::div_t     ex_div_rdata_i,
  input  logic                              ex_err_i,
  output logic                              rsp_valid_o,
  output hemaia_mem_chip_bus_pkg::data_t    rsp_rdata_o,
  output logic                              rsp_err_o
);
  import hemaia_mem_chip_addr_pkg::*;
  import hemaia_mem_chip_bus_pkg::*;

  data_t rdata_d;
  data_t rdata_q;
  logic  valid_q;
  logic  err_q;

  always_comb begin
    rdata_d = '0;
    if (ex_valid_i && !ex_err_i && (ex_op_i == OpRead)) begin
      case (ex_target_i)
        TgtMem:     rdata_d = ex_bank_rdata_i[ex_bank_i];
        // Division value comes back zero-extended
        TgtClkCtrl: rdata_d = data_t'(ex_div_rdata_i);
        default:    rdata_d = '0;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
      err_q   <= 1'b0;
    end else begin
      valid_q <= ex_valid_i;
      err_q   <= ex_err_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (ex_valid_i) begin
      rdata_q <= rdata_d;
    end
  end

  assign rsp_valid_o = valid_q;
  assign rsp_rdata_o = rdata_q;
  assign rsp_err_o   = err_q;

  // Error flag rides along from execute, so it must come with a valid
  err_with_valid_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    rsp_err_o |-> rsp_valid_o);

endmodule

`default_nettype wire

// File: hw/hemaia_mem_chip.sv
// HeMAiA memory chip local-access fabric
// Single request port into a decode, execute and response pipeline
// covering the banked SRAM and the clock-divider registers

`timescale 1ns/1ps
`default_nettype none

module hemaia_mem_chip #(
  parameter int unsigned MemSize    = 32'h1000,
  parameter int unsigned MemBankNum = 4
) (
  input  logic                               clk_i,
  input  logic                               rst_ni,
  input  hemaia_mem_chip_addr_pkg::chip_id_t chip_id_i,
  input  logic                               req_valid_i,
  input  hemaia_mem_chip_bus_pkg::op_e       req_op_i,
  input  hemaia_mem_chip_addr_pkg::addr_t    req_addr_i,
  input  hemaia_mem_chip_bus_pkg::data_t     req_wdata_i,
  output logic                               rsp_valid_o,
  output hemaia_mem_chip_bus_pkg::data_t     rsp_rdata_o,
  output logic                               rsp_err_o
);
  import hemaia_mem_chip_addr_pkg::*;
  import hemaia_mem_chip_bus_pkg::*;

  localparam int unsigned IdxWidth  = word_idx_width(MemSize, NumClocks);
  localparam int unsigned BankWidth = idx_width(MemBankNum);

  logic                 ex_valid;
  op_e                  ex_op;
  target_e              ex_target;
  logic [BankWidth-1:0] ex_bank;
  data_t                ex_bank_rdata[MemBankNum];
  div_t                 ex_div_rdata;
  logic                 ex_err;

  hemaia_mem_req_if #(
    .IdxWidth(IdxWidth)
  ) dec_req ();

  hemaia_addr_decode #(
    .MemSize(MemSize)
  ) u_decode (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .chip_id_i  (chip_id_i),
    .req_valid_i(req_valid_i),
    .req_op_i   (req_op_i),
    .req_addr_i (req_addr_i),
    .req_wdata_i(req_wdata_i),
    .req_o      (dec_req)
  );

  hemaia_target_exec #(
    .MemSize   (MemSize),
    .MemBankNum(MemBankNum)
  ) u_exec (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .req_i          (dec_req),
    .ex_valid_o     (ex_valid),
    .ex_op_o        (ex_op),
    .ex_target_o    (ex_target),
    .ex_bank_o      (ex_bank),
    .ex_bank_rdata_o(ex_bank_rdata),
    .ex_div_rdata_o (ex_div_rdata),
    .ex_err_o       (ex_err)
  );

  hemaia_resp_merge #(
    .MemBankNum(MemBankNum)
  ) u_merge (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .ex_valid_i     (ex_valid),
    .ex_op_i        (ex_op),
    .ex_target_i    (ex_target),
    .ex_bank_i      (ex_bank),
    .ex_bank_rdata_i(ex_bank_rdata),
    .ex_div_rdata_i (ex_div_rdata),
    .ex_err_i       (ex_err),
    .rsp_valid_o    (rsp_valid_o),
    .rsp_rdata_o    (rsp_rdata_o),
    .rsp_err_o      (rsp_err_o)
  );

endmodule

`default_nettype wire

// File: test/tb_hemaia_mem_chip.sv
// Testbench for the memory chip local-access fabric
// Applies a stimulus table back to back and checks every response
// against a reference model of the SRAM and the divider registers

`timescale 1ns/1ps
`default_nettype none

module tb_hemaia_mem_chip;
  import hemaia_mem_chip_addr_pkg::*;
  import hemaia_mem_chip_bus_pkg::*;

  localparam int unsigned ClkPeriod = 20;
  localparam chip_id_t    LocalChip = 8'h2A;
  localparam offset_t     LinkOffset = 40'h0002007000;

  typedef struct {
    op_e      op;
    offset_t  offset;
    logic     chip_ovr;
    chip_id_t chip;
    logic     use_rand;
    data_t    wdata;
    logic     use_model;
    data_t    exp_rdata;
    logic     exp_err;
  } step_t;

  typedef struct {
    data_t       rdata;
    logic        err;
    int unsigned rsp_cycle;
    int unsigned idx;
  } expect_t;

  logic     clk_i = 1'b0;
  logic     rst_ni;
  chip_id_t chip_id_i;
  logic     req_valid_i;
  op_e      req_op_i;
  addr_t    req_addr_i;
  data_t    req_wdata_i;
  logic     rsp_valid_o;
  data_t    rsp_rdata_o;
  logic     rsp_err_o;

  step_t       steps[$];
  expect_t     exp_q[$];
  data_t       mem_model[int unsigned];
  div_t        div_model[5];
  integer      seed = 32'h0b1d48cc;
  int unsigned cycle = 0;
  logic        steps_ready = 1'b0;

  hemaia_mem_chip dut0 (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .chip_id_i  (chip_id_i),
    .req_valid_i(req_valid_i),
    .req_op_i   (req_op_i),
    .req_addr_i (req_addr_i),
    .req_wdata_i(req_wdata_i),
    .rsp_valid_o(rsp_valid_o),
    .rsp_rdata_o(rsp_rdata_o),
    .rsp_err_o  (rsp_err_o)
  );

  always #(ClkPeriod / 2) clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cycle <= cycle + 1;
  end

  task automatic report_failure(input string msg);
    $display("ERROR %0d ns: %s", $time, msg);
    $display("Simulation finished: FAIL");
    $fatal(1, "Stopping at the first failed check");
  endtask

  function automatic offset_t mem_off(input int unsigned word);
    return MemBaseOffset + offset_t'(word << 3);
  endfunction

  function automatic offset_t div_off(input int unsigned idx);
    return ClkCtrlBaseOffset + offset_t'(idx << 3);
  endfunction

  task automatic add_step(input op_e op, input offset_t offset, input logic chip_ovr,
                          input chip_id_t chip, input logic use_rand, input data_t wdata,
                          input logic use_model, input data_t exp_rdata,
                          input logic exp_err);
    step_t st;
    st = '{op, offset, chip_ovr, chip, use_rand, wdata, use_model, exp_rdata, exp_err};
    steps.push_back(st);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus table
  ////////////////////////////////////////////////////////////////////////////

  task automatic build_table();
    // Divider reset values
    add_step(OpRead,  div_off(0), 1'b0, 8'h00, 1'b0, '0, 1'b0, 64'd4, 1'b0);
    add_step(OpRead,  div_off(1), 1'b0, 8'h00, 1'b0, '0, 1'b0, 64'd1, 1'b0);
    add_step(OpRead,  div_off(2), 1'b0, 8'h00, 1'b0, '0, 1'b0, 64'd1, 1'b0);
    add_step(OpRead,  div_off(3), 1'b0, 8'h00, 1'b0, '0, 1'b0, 64'd1, 1'b0);
    add_step(OpRead,  div_off(4), 1'b0, 8'h00, 1'b0, '0, 1'b0, 64'd1, 1'b0);
    // Consecutive words cover every bank twice
    for (int unsigned w = 0; w < 8; w++) begin
      add_step(OpWrite, mem_off(w), 1'b0, 8'h00, 1'b1, '0, 1'b0, '0, 1'b0);
    end
    for (int unsigned w = 0; w < 8; w++) begin
      add_step(OpRead,  mem_off(w), 1'b0, 8'h00, 1'b0, '0, 1'b1, '0, 1'b0);
    end
    // Read right behind the write to the same word
    add_step(OpWrite, mem_off(8), 1'b0, 8'h00, 1'b1, '0, 1'b0, '0, 1'b0);
    add_step(OpRead,  mem_off(8), 1'b0, 8'h00, 1'b0, '0, 1'b1, '0, 1'b0);
    add_step(OpWrite, mem_off(9), 1'b0, 8'h00, 1'b1, '0, 1'b0, '0, 1'b0);
    add_step(OpRead,  mem_off(9), 1'b0, 8'h00, 1'b0, '0, 1'b1, '0, 1'b0);
    // Divider keeps only the low byte
    add_step(OpWrite, div_off(2), 1'b0, 8'h00, 1'b0, 64'h0123_4567_89AB_CDA7, 1'b0, '0, 1'b0);
    add_step(OpRead,  div_off(2), 1'b0, 8'h00, 1'b0, '0, 1'b0, 64'hA7, 1'b0);
    add_step(OpWrite, div_off(0), 1'b0, 8'h00, 1'b1, '0, 1'b0, '0, 1'b0);
    add_step(OpRead,  div_off(0), 1'b0, 8'h00, 1'b0, '0, 1'b1, '0, 1'b0);
    add_step(OpRead,  div_off(4), 1'b0, 8'h00, 1'b0, '0, 1'b1, '0, 1'b0);
    // Remote chip, link control, holes and the missing sixth divider
    add_step(OpWrite, mem_off(0), 1'b1, 8'h7E, 1'b1, '0, 1'b0, '0, 1'b1);
    add_step(OpRead,  mem_off(0), 1'b1, 8'h7E, 1'b0, '0, 1'b0, '0, 1'b1);
    add_step(OpRead,  mem_off(0), 1'b0, 8'h00, 1'b0, '0, 1'b1, '0, 1'b0);
    add_step(OpRead,  LinkOffset, 1'b0, 8'h00, 1'b0, '0, 1'b0, '0, 1'b1);
    add_step(OpWrite, LinkOffset, 1'b0, 8'h00, 1'b1, '0, 1'b0, '0, 1'b1);
    add_step(OpRead,  40'h0000001000, 1'b0, 8'h00, 1'b0, '0, 1'b0, '0, 1'b1);
    add_step(OpWrite, mem_off(512), 1'b0, 8'h00, 1'b1, '0, 1'b0, '0, 1'b1);
    add_step(OpWrite, div_off(5), 1'b0, 8'h00, 1'b1, '0, 1'b0, '0, 1'b1);
    add_step(OpRead,  div_off(5), 1'b0, 8'h00, 1'b0, '0, 1'b0, '0, 1'b1);
    add_step(OpRead,  div_off(2), 1'b0, 8'h00, 1'b0, '0, 1'b1, '0, 1'b0);
    // Pins now show 8'h11 but the captured ID stays
    add_step(OpRead,  mem_off(1), 1'b1, 8'h11, 1'b0, '0, 1'b0, '0, 1'b1);
    add_step(OpWrite, mem_off(1), 1'b1, 8'h11, 1'b1, '0, 1'b0, '0, 1'b1);
    add_step(OpRead,  mem_off(1), 1'b0, 8'h00, 1'b0, '0, 1'b1, '0, 1'b0);
  endtask

  // Drives one request and queues its expected response
  task automatic apply_step(input int unsigned k);
    step_t       st;
    data_t       wdata;
    expect_t     exp;
    int unsigned idx;
    st    = steps[k];
    wdata = st.wdata;
    if (st.use_rand) begin
      wdata = {$random(seed), $random(seed)};
    end
    exp = '{64'd0, st.exp_err, cycle + 3, k};
    if (!st.exp_err && (st.offset >= MemBaseOffset)) begin
      idx = int'((st.offset - MemBaseOffset) >> 3);
      if (st.op == OpWrite) begin
        mem_model[idx] = wdata;
      end else begin
        exp.rdata = st.use_model ? mem_model[idx] : st.exp_rdata;
      end
    end else if (!st.exp_err) begin
      idx = int'((st.offset - ClkCtrlBaseOffset) >> 3);
      if (st.op == OpWrite) begin
        div_model[idx] = wdata[7:0];
      end else begin
        exp.rdata = st.use_model ? {56'd0, div_model[idx]} : st.exp_rdata;
      end
    end
    req_valid_i = 1'b1;
    req_op_i    = st.op;
    req_addr_i  = {st.chip_ovr ? st.chip : LocalChip, st.offset};
    req_wdata_i = wdata;
    exp_q.push_back(exp);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Response checks
  ////////////////////////////////////////////////////////////////////////////

  always @(negedge clk_i) begin : check_rsp
    expect_t head;
    if (rsp_valid_o === 1'b1) begin
      assert (exp_q.size() != 0)
        else report_failure("response arrived with no request outstanding");
      head = exp_q.pop_front();
      assert (cycle == head.rsp_cycle)
        else report_failure($sformatf("step %0d response at cycle %0d, expected %0d",
                                      head.idx, cycle, head.rsp_cycle));
      assert (rsp_err_o === head.err)
        else report_failure($sformatf("step %0d err %b, expected %b",
                                      head.idx, rsp_err_o, head.err));
      assert (rsp_rdata_o === head.rdata)
        else report_failure($sformatf("step %0d rdata %h, expected %h",
                                      head.idx, rsp_rdata_o, head.rdata));
    end else begin
      assert (rsp_valid_o === 1'b0) else report_failure("rsp_valid_o is unknown");
      assert (rsp_err_o === 1'b0) else report_failure("rsp_err_o high without a response");
      if (exp_q.size() != 0) begin
        assert (cycle < exp_q[0].rsp_cycle)
          else report_failure($sformatf("step %0d response missing", exp_q[0].idx));
      end
    end
  end

  initial begin
    wait (steps_ready);
    #((steps.size() + 20) * ClkPeriod);
    $display("Watchdog expired before all responses came back");
    $display("Simulation finished: FAIL");
    $fatal(1, "Run timed out");
  end

  initial begin
    rst_ni      = 1'b0;
    chip_id_i   = LocalChip;
    req_valid_i = 1'b0;
    req_op_i    = OpRead;
    req_addr_i  = '0;
    req_wdata_i = '0;
    div_model   = '{8'd4, 8'd1, 8'd1, 8'd1, 8'd1};
    build_table();
    steps_ready = 1'b1;

    repeat (8) @(posedge clk_i);
    #2;
    rst_ni    = 1'b1;
    chip_id_i = 8'h11;
    repeat (2) @(posedge clk_i);

    for (int unsigned k = 0; k < steps.size(); k++) begin
      @(posedge clk_i);
      #2;
      apply_step(k);
    end
    @(posedge clk_i);
    #2;
    req_valid_i = 1'b0;

    while (exp_q.size() != 0) begin
      @(posedge clk_i);
    end
    @(posedge clk_i);

    $display("Simulation finished: PASS");
    $finish;
  end

endmodule

`default_nettype wire

// File: hemaia_mem_chip.f
hw/hemaia_mem_chip_addr_pkg.sv
hw/hemaia_mem_chip_bus_pkg.sv
hw/hemaia_mem_req_if.sv
hw/hemaia_addr_decode.sv
hw/hemaia_target_exec.sv
hw/hemaia_resp_merge.sv
hw/hemaia_mem_chip.sv
test/tb_hemaia_mem_chip.sv

// File: Makefile
# Verilator build and run for the memory chip local-access fabric

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := tb_hemaia_mem_chip
FILELIST  := hemaia_mem_chip.f
BUILD_DIR := obj_dir
LOG       := sim.log
PASS_MSG  := Simulation finished: PASS

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	-./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || (echo "Run failed, see $(LOG)"; exit 1)
	@echo "Run passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
